//--- src.f
hdl/chk_pkg.sv
hdl/pattern_pkg.sv
hdl/pkt_chk_fsm.sv
hdl/exp_data_gen.sv
hdl/seg_compare.sv
hdl/txn_counter.sv
hdl/pkt_chk_top.sv
bench/tb_pkt_chk.sv

//--- Makefile
# Verilator build and run for the stream receive checker

VERILATOR  ?= verilator
TOP        := tb_pkt_chk
FILELIST   := src.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --timescale 1ns/100ps -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
PASS_MSG   := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/pkt_cases.txt
# kind words corrupt_idx xor_mask_hex gap exp_total exp_match exp_fail (counts since reset)
# kind 0 checks only, 1 start edge then stream, 2 stream on, 3 stream with enable drop
0 0 -1 0000000000000000 0 0 0 0
1 16 -1 0000000000000000 0 16 16 0
2 12 -1 0000000000000000 0 28 28 0
2 10 4 00000000000000ff 0 38 37 1
2 8 -1 0000000000000000 0 46 45 1
3 20 -1 0000000000000000 0 66 65 1
1 10 -1 0000000000000000 0 76 75 1
2 24 -1 0000000000000000 1 100 99 1
1 15 -1 0000000000000000 1 115 114 1
3 18 7 8000000000000000 1 133 131 2
2 30 0 0000000000010000 0 163 160 3
1 40 -1 0000000000000000 1 203 200 3
3 25 24 ffffffffffffffff 0 228 224 4
2 32 -1 0000000000000000 1 260 256 4
1 12 -1 0000000000000000 0 272 268 4
3 16 -1 0000000000000000 1 288 284 4
2 20 3 0000ff0000000000 1 308 303 5
2 10 -1 0000000000000000 0 318 313 5

//--- bench/tb_pkt_chk.sv
// --------------------------------------------------
// testbench for the stream receive checker with table
// driven cases against a lane LFSR reference model
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_pkt_chk;

   localparam int HOLD_CYC  = 10;   // enable low window
   localparam int IDLE_CYC  = 8;    // drain before count checks
   localparam int READY_MAX = 40;

   logic i_clk;
   logic i_reset_n;
   logic i_start;
   logic i_enable;
   logic i_valid;
   logic [chk_pkg::DATA_W-1:0] i_data;
   logic o_ready;
   logic o_pkt_error;
   logic [chk_pkg::CNT_W-1:0] o_total_count;
   logic [chk_pkg::CNT_W-1:0] o_match_count;
   logic [chk_pkg::CNT_W-1:0] o_fail_count;

   // case table with one entry per data line
   int          c_kind[$];
   int          c_words[$];
   int          c_bad[$];
   logic [63:0] c_mask[$];
   int          c_gaps[$];
   int          c_total[$];
   int          c_match[$];
   int          c_fail[$];

   logic [pattern_pkg::LANE_W-1:0] lane_st [pattern_pkg::N_LANE];   // model lanes
   int m_total;   // words accepted so far
   bit m_seen;
   bit m_err;     // some word was corrupted
   int error_count;
   int cycle_cnt = 0;
   int cycle_limit = 0;

   pkt_chk_top dut_i (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_start       (i_start),
      .i_enable      (i_enable),
      .i_valid       (i_valid),
      .i_data        (i_data),
      .o_ready       (o_ready),
      .o_pkt_error   (o_pkt_error),
      .o_total_count (o_total_count),
      .o_match_count (o_match_count),
      .o_fail_count  (o_fail_count)
   );

   initial
   begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;   // 20 ns period
   end

   // run limit set once the table is read
   always @(posedge i_clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit)
      begin
         $display("run stopped, no verdict after %0d cycles", cycle_limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   function automatic logic [pattern_pkg::LANE_W-1:0] shift_lane(
      input logic [pattern_pkg::LANE_W-1:0] v);
      logic [pattern_pkg::LANE_W-1:0] r;
      r = {1'b0, v[pattern_pkg::LANE_W-1:1]};
      if (v[0])
         r = r ^ pattern_pkg::LFSR_TAPS;   // galois feedback
      return r;
   endfunction

   function automatic logic [chk_pkg::DATA_W-1:0] model_word();
      logic [chk_pkg::DATA_W-1:0] w;
      for (int i = 0; i < pattern_pkg::N_LANE; i++)
         w[i*pattern_pkg::LANE_W +: pattern_pkg::LANE_W] = lane_st[i];
      return w;
   endfunction

   task automatic reload_model();
      for (int i = 0; i < pattern_pkg::N_LANE; i++)
         lane_st[i] = pattern_pkg::SEED_BASE + 8'(i);   // linear first word
   endtask

   task automatic advance_model();
      for (int i = 0; i < pattern_pkg::N_LANE; i++)
         lane_st[i] = shift_lane(lane_st[i]);
   endtask

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      if (got !== exp)
      begin
         error_count++;
         $display("FAIL %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic load_cases();
      int          fd;
      int          n;
      string       line;
      int          kind;
      int          words;
      int          bad;
      logic [63:0] mask;
      int          gaps;
      int          tot;
      int          mat;
      int          fai;
      fd = $fopen("bench/pkt_cases.txt", "r");
      if (fd == 0)
      begin
         error_count++;
         $display("ERROR case file bench/pkt_cases.txt could not be opened");
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#")
         begin
            n = $sscanf(line, "%d %d %d %h %d %d %d %d",
                        kind, words, bad, mask, gaps, tot, mat, fai);
            if (n == 8)
            begin
               c_kind.push_back(kind);
               c_words.push_back(words);
               c_bad.push_back(bad);
               c_mask.push_back(mask);
               c_gaps.push_back(gaps);
               c_total.push_back(tot);
               c_match.push_back(mat);
               c_fail.push_back(fai);
            end
            else
            begin
               error_count++;
               $display("ERROR malformed case line: %s", line);
            end
         end
      end
      $fclose(fd);
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   task automatic wait_ready(input logic lvl);
      int n;
      n = 0;
      while (o_ready !== lvl && n < READY_MAX)
      begin
         @(posedge i_clk);
         #2;
         n++;
      end
      if (o_ready !== lvl)
      begin
         error_count++;
         $display("ERROR o_ready never went to %0d after the start edge", lvl);
      end
   endtask

   task automatic do_start();
      i_enable = 1'b1;
      i_start  = 1'b1;   // rising edge
      @(posedge i_clk);
      #2;
      i_start = 1'b0;
      reload_model();
      wait_ready(1'b0);  // fsm passes through idle
      wait_ready(1'b1);
   endtask

   // a word stays on the bus until ready takes it
   task automatic send_words(input int n, input int bad_idx, input logic [63:0] mask,
                             input bit gaps, input bit bp);
      int          sent;
      int          hold_cnt;
      bit          on_bus;
      bit          rdy;
      bit          is_bad;
      logic [63:0] word;
      sent = 0;
      hold_cnt = 0;
      on_bus = 1'b0;
      while (sent < n)
      begin
         if (bp && sent >= n / 2 && hold_cnt <= HOLD_CYC)
         begin
            i_enable = (hold_cnt == HOLD_CYC);   // low for HOLD_CYC cycles
            if (hold_cnt == HOLD_CYC - 1)
            begin
               check_val("o_ready", 64'(o_ready), 64'd0);
               check_val("o_total_count", 64'(o_total_count), 64'(m_total));
            end
            hold_cnt++;
         end
         if (!on_bus)
            on_bus = !(gaps && i_enable && ($urandom % 4) == 0);   // gap cycle
         is_bad = (sent == bad_idx);
         word = model_word();
         if (is_bad)
            word = word ^ mask;
         i_valid = on_bus;
         i_data = on_bus ? word : ~word;
         rdy = o_ready;   // stable until the next edge
         @(posedge i_clk);
         #2;
         if (on_bus && rdy)
         begin
            m_total++;
            m_seen = 1'b1;
            if (is_bad)
               m_err = 1'b1;
            advance_model();
            sent++;
            on_bus = 1'b0;
         end
      end
      i_valid = 1'b0;
      i_enable = 1'b1;
   endtask

   task automatic run_case(input int k);
      case (c_kind[k])
         0 :
         begin
            // idle case with checks only
         end
         1 :
         begin
            do_start();
            send_words(c_words[k], c_bad[k], c_mask[k], c_gaps[k] != 0, 1'b0);
         end
         2 : send_words(c_words[k], c_bad[k], c_mask[k], c_gaps[k] != 0, 1'b0);
         3 : send_words(c_words[k], c_bad[k], c_mask[k], c_gaps[k] != 0, 1'b1);
         default :
         begin
            error_count++;
            $display("ERROR case %0d has unknown kind %0d", k, c_kind[k]);
         end
      endcase
      repeat (IDLE_CYC) @(posedge i_clk);
      #2;
      check_val("o_total_count", 64'(o_total_count), 64'(c_total[k]));
      check_val("o_match_count", 64'(o_match_count), 64'(c_match[k]));
      check_val("o_fail_count", 64'(o_fail_count), 64'(c_fail[k]));
      check_val("o_pkt_error", 64'(o_pkt_error), 64'(m_err || !m_seen));
   endtask

   initial
   begin
      int sum_words;
      i_reset_n = 1'b0;
      i_start = 1'b0;
      i_enable = 1'b0;
      i_valid = 1'b0;
      i_data = '0;
      error_count = 0;
      m_total = 0;
      m_seen = 1'b0;
      m_err = 1'b0;
      sum_words = 0;
      void'($urandom(88594));
      load_cases();
      if (c_kind.size() == 0)
      begin
         error_count++;
         $display("ERROR no cases were loaded");
      end
      foreach (c_words[k])
         sum_words += c_words[k];
      cycle_limit = sum_words * 4 + 200 * c_kind.size();
      reload_model();
      repeat (2) @(posedge i_clk);   // reset held two cycles
      #2;
      i_reset_n = 1'b1;
      for (int k = 0; k < c_kind.size(); k++)
         run_case(k);
      $display("errors %0d, cases %0d, words %0d", error_count, c_kind.size(), m_total);
      if (error_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule : tb_pkt_chk

`default_nettype wire

//--- hdl/pkt_chk_top.sv
// --------------------------------------------------
// stream receive checker top, control, generator,
// compare and three transaction counters
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_chk_top (
   input  wire                        i_clk,
   input  wire                        i_reset_n,
   input  wire                        i_start,
   input  wire                        i_enable,
   input  wire                        i_valid,
   input  wire  [chk_pkg::DATA_W-1:0] i_data,
   output logic                       o_ready,
   output logic                       o_pkt_error,
   output logic [chk_pkg::CNT_W-1:0]  o_total_count,
   output logic [chk_pkg::CNT_W-1:0]  o_match_count,
   output logic [chk_pkg::CNT_W-1:0]  o_fail_count
);

   logic accept;
   logic gen_first;
   logic restart;
   logic beat_done;
   logic match_inc;
   logic fail_inc;
   logic [chk_pkg::DATA_W-1:0] exp_data;

   // --------------------------------------------------
   // control and expected data
   // --------------------------------------------------
   pkt_chk_fsm fsm_i (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_start     (i_start),
      .i_enable    (i_enable),
      .i_valid     (i_valid),
      .o_ready     (o_ready),
      .o_accept    (accept),
      .o_gen_first (gen_first),
      .o_restart   (restart)
   );

   exp_data_gen gen_i (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_restart  (restart),
      .i_first    (gen_first),
      .i_accept   (accept),
      .o_exp_data (exp_data)
   );

   seg_compare cmp_i (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_accept    (accept),
      .i_data      (i_data),
      .i_exp_data  (exp_data),
      .o_beat_done (beat_done),
      .o_match_inc (match_inc),
      .o_fail_inc  (fail_inc),
      .o_pkt_error (o_pkt_error)
   );

   // counters, total sees every beat
   txn_counter total_cnt_i (.i_clk(i_clk), .i_reset_n(i_reset_n),
                            .i_inc(beat_done), .o_count(o_total_count));
   txn_counter match_cnt_i (.i_clk(i_clk), .i_reset_n(i_reset_n),
                            .i_inc(match_inc), .o_count(o_match_count));
   txn_counter fail_cnt_i  (.i_clk(i_clk), .i_reset_n(i_reset_n),
                            .i_inc(fail_inc),  .o_count(o_fail_count));

endmodule : pkt_chk_top

`default_nettype wire

//--- hdl/txn_counter.sv
// --------------------------------------------------
// 32 bit event counter, two 16 bit halves with a
// registered carry between them
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module txn_counter (
   input  wire                       i_clk,
   input  wire                       i_reset_n,
   input  wire                       i_inc,     // one count per high cycle
   output logic [chk_pkg::CNT_W-1:0] o_count
);

   logic [chk_pkg::CNT_HALF_W-1:0] low_q;
   logic [chk_pkg::CNT_HALF_W-1:0] low_d;    // lines up with high half
   logic [chk_pkg::CNT_HALF_W-1:0] high_q;
   logic                           carry_q;  // low half wrapped

   // low half and carry
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         low_q   <= '0;
         low_d   <= '0;
         carry_q <= 1'b0;
      end
      else
      begin
         low_d   <= low_q;
         carry_q <= i_inc && (low_q == '1);
         if (i_inc)
            low_q <= low_q + 1'b1;
      end
   end

   // high half, one cycle after the wrap
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
         high_q <= '0;
      else if (carry_q)
         high_q <= high_q + 1'b1;
   end

   assign o_count = {high_q, low_d};

endmodule : txn_counter

`default_nettype wire

//--- hdl/seg_compare.sv
// --------------------------------------------------
// two-stage segment compare, beat strobes and the
// sticky error flag
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module seg_compare (
   input  wire                        i_clk,
   input  wire                        i_reset_n,
   input  wire                        i_accept,     // data_q holds an accepted word
   input  wire  [chk_pkg::DATA_W-1:0] i_data,       // raw bus data
   input  wire  [chk_pkg::DATA_W-1:0] i_exp_data,   // generator word
   output logic                       o_beat_done,  // one word checked
   output logic                       o_match_inc,
   output logic                       o_fail_inc,
   output logic                       o_pkt_error   // sticky, also high before first word
);

   logic [chk_pkg::DATA_W-1:0]  data_q;     // bus word, one cycle back
   logic [chk_pkg::N_SEG-1:0]   seg_eq_q;   // stage 1
   logic [chk_pkg::N_GROUP-1:0] grp_eq_q;   // stage 2
   logic acc_d1;
   logic acc_d2;
   logic word_ok;
   logic beat_q;
   logic match_q;
   logic fail_q;
   logic seen_q;        // at least one word checked
   logic err_latch_q;   // any word failed
   logic pkt_error_q;

   // capture every cycle, the accept strobe picks the word
   always_ff @(posedge i_clk)
   begin
      data_q <= i_data;
   end

   // --------------------------------------------------
   // stage 1, per segment equality
   // --------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
         seg_eq_q <= '0;
      else if (i_accept)
         for (int s = 0; s < chk_pkg::N_SEG; s++)
            seg_eq_q[s] <= (data_q[s*chk_pkg::SEG_W +: chk_pkg::SEG_W] ==
                            i_exp_data[s*chk_pkg::SEG_W +: chk_pkg::SEG_W]);
   end

   // stage 2, and the flags in groups
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
         grp_eq_q <= '0;
      else if (acc_d1)
         for (int g = 0; g < chk_pkg::N_GROUP; g++)
            grp_eq_q[g] <= &seg_eq_q[g*chk_pkg::SEGS_PER_GROUP +: chk_pkg::SEGS_PER_GROUP];
   end

   // accept follows the data down the pipe
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         acc_d1 <= 1'b0;
         acc_d2 <= 1'b0;
      end
      else
      begin
         acc_d1 <= i_accept;
         acc_d2 <= acc_d1;
      end
   end

   assign word_ok = &grp_eq_q;

   // --------------------------------------------------
   // beat strobes and error state
   // --------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         beat_q      <= 1'b0;
         match_q     <= 1'b0;
         fail_q      <= 1'b0;
         seen_q      <= 1'b0;
         err_latch_q <= 1'b0;
         pkt_error_q <= 1'b1;   // nothing seen yet
      end
      else
      begin
         beat_q  <= acc_d2;
         match_q <= acc_d2 & word_ok;
         fail_q  <= acc_d2 & ~word_ok;
         if (acc_d2)
            seen_q <= 1'b1;
         if (acc_d2 && !word_ok)
            err_latch_q <= 1'b1;                 // never cleared
         pkt_error_q <= err_latch_q | ~seen_q;   // one cycle behind the strobes
      end
   end

   assign o_beat_done = beat_q;
   assign o_match_inc = match_q;
   assign o_fail_inc  = fail_q;
   assign o_pkt_error = pkt_error_q;

endmodule : seg_compare

`default_nettype wire

//--- hdl/exp_data_gen.sv
// --------------------------------------------------
// expected word generator, one galois LFSR per lane
// reload on restart, step on first value or accept
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module exp_data_gen (
   input  wire  i_clk,
   input  wire  i_reset_n,
   input  wire  i_restart,   // reload all lanes to seed
   input  wire  i_first,     // first-value step
   input  wire  i_accept,    // one accepted word, step
   output logic [pattern_pkg::LANE_W*pattern_pkg::N_LANE-1:0] o_exp_data
);

   logic step;
   logic first_hold_q;   // next step keeps the seed word

   // one shift of a lane
   function automatic logic [pattern_pkg::LANE_W-1:0] lfsr_next(
      input logic [pattern_pkg::LANE_W-1:0] s);
      logic [pattern_pkg::LANE_W-1:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ pattern_pkg::LFSR_TAPS;   // galois feedback
      return n;
   endfunction

   // reload value of lane idx
   function automatic logic [pattern_pkg::LANE_W-1:0] lane_seed(input int idx);
      int sum;
      sum = int'(pattern_pkg::SEED_BASE) + idx;
      return sum[pattern_pkg::LANE_W-1:0];
   endfunction

   assign step = i_first | i_accept;

   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n || i_restart)
         first_hold_q <= pattern_pkg::FIRST_WORD_LINEAR;
      else if (step)
         first_hold_q <= 1'b0;
   end

   // --------------------------------------------------
   // lanes, all step together
   // --------------------------------------------------
   for (genvar g = 0; g < pattern_pkg::N_LANE; g++)
   begin : g_lane
      logic [pattern_pkg::LANE_W-1:0] lane_q;

      always_ff @(posedge i_clk)
      begin
         if (!i_reset_n || i_restart)
            lane_q <= lane_seed(g);               // linear first word
         else if (step && !first_hold_q)
            lane_q <= lfsr_next(lane_q);
      end

      assign o_exp_data[g*pattern_pkg::LANE_W +: pattern_pkg::LANE_W] = lane_q;
   end

endmodule : exp_data_gen

`default_nettype wire

//--- hdl/pkt_chk_fsm.sv
// --------------------------------------------------
// checker control: start edge, state machine,
// ready output and registered accept strobe
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_chk_fsm (
   input  wire  i_clk,
   input  wire  i_reset_n,    // sync, active low
   input  wire  i_start,      // rising edge restarts pattern
   input  wire  i_enable,     // level, allows ready
   input  wire  i_valid,      // source has a word
   output logic o_ready,
   output logic o_accept,     // handshake, one cycle late
   output logic o_gen_first,  // first-value step pulse
   output logic o_restart     // generator reload
);

   chk_pkg::chk_state_t state_q;

   logic start_d;      // i_start one cycle back
   logic first_pend;   // restart seen, first value still owed
   logic ready_q;
   logic accept_q;
   logic gen_first_q;

   // edge detect, reload lands on the next clock edge
   assign o_restart = i_start & ~start_d;

   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
         start_d <= 1'b0;
      else
         start_d <= i_start;
   end

   // pending flag, set wins over clear
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
         first_pend <= 1'b0;
      else if (o_restart)
         first_pend <= 1'b1;
      else if (state_q == chk_pkg::CHK_GEN_FIRST)
         first_pend <= 1'b0;   // owed step goes out now
   end

   // --------------------------------------------------
   // state machine
   // --------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      gen_first_q <= 1'b0;   // single cycle pulse
      if (!i_reset_n)
      begin
         state_q <= chk_pkg::CHK_IDLE;
         ready_q <= 1'b0;
      end
      else
      begin
         case (state_q)
            chk_pkg::CHK_IDLE :
            begin
               ready_q <= 1'b0;
               if (i_enable)
                  state_q <= first_pend ? chk_pkg::CHK_GEN_FIRST : chk_pkg::CHK_RUNNING;
            end
            chk_pkg::CHK_GEN_FIRST :
            begin
               gen_first_q <= 1'b1;        // step generator off the seed
               ready_q     <= 1'b0;
               state_q     <= chk_pkg::CHK_RUNNING;
            end
            chk_pkg::CHK_RUNNING :
            begin
               if (i_enable && !first_pend)
                  ready_q <= 1'b1;         // rises one edge into running
               else
               begin
                  ready_q <= 1'b0;         // disable or fresh restart
                  state_q <= chk_pkg::CHK_IDLE;
               end
            end
            default :
            begin
               ready_q <= 1'b0;
               state_q <= chk_pkg::CHK_IDLE;
            end
         endcase
      end
   end

   // accepted word, seen by compare and generator next cycle
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
         accept_q <= 1'b0;
      else
         accept_q <= ready_q & i_valid;
   end

   assign o_ready     = ready_q;
   assign o_accept    = accept_q;
   assign o_gen_first = gen_first_q;

endmodule : pkt_chk_fsm

`default_nettype wire

//--- hdl/pattern_pkg.sv
// --------------------------------------------------
// expected-data pattern constants, lane LFSRs
// --------------------------------------------------
`default_nettype none

package pattern_pkg;

   // lane geometry, N_LANE lanes fill one bus word
   localparam int LANE_W = 8;
   localparam int N_LANE = 8;

   // galois taps for x^8+x^6+x^5+x^4+1
   // right-shift form, xor in when the lsb falls out
   localparam logic [LANE_W-1:0] LFSR_TAPS = 8'hB8;

   // reload value of lane 0, lane i gets SEED_BASE + i
   // so the reloaded word reads 0x0706050403020100
   localparam logic [LANE_W-1:0] SEED_BASE = 8'h00;

   // first-word rule
   // when set, the first step after a reload keeps the
   // seed word, so the first word on the bus is linear
   localparam bit FIRST_WORD_LINEAR = 1'b1;

endpackage : pattern_pkg

`default_nettype wire

//--- hdl/chk_pkg.sv
// --------------------------------------------------
// checker structure constants and state encoding
// for the stream receive checker
// --------------------------------------------------
`default_nettype none

package chk_pkg;

   // --------------------------------------------------
   // data path geometry
   // --------------------------------------------------
   localparam int DATA_W = 64;                     // stream word width
   localparam int SEG_W  = 16;                     // stage-1 compare slice
   localparam int N_SEG  = DATA_W / SEG_W;         // 4 slices per word

   // stage-2 reduction, groups of slice flags
   localparam int SEGS_PER_GROUP = 2;
   localparam int N_GROUP        = N_SEG / SEGS_PER_GROUP;

   // --------------------------------------------------
   // transaction counters
   // --------------------------------------------------
   localparam int CNT_HALF_W = 16;                 // one counter half
   localparam int CNT_W      = 2 * CNT_HALF_W;     // full count, 32 bits

   // --------------------------------------------------
   // checker control states
   // --------------------------------------------------
   // CHK_IDLE      ready low, waiting on enable
   // CHK_GEN_FIRST one pass to pulse the first-value step
   // CHK_RUNNING   ready follows enable
   typedef enum logic [1:0] {
      CHK_IDLE      = 2'd0,
      CHK_GEN_FIRST = 2'd1,
      CHK_RUNNING   = 2'd2
   } chk_state_t;

endpackage : chk_pkg

`default_nettype wire
